/* rtl/csr_pkg.sv */
// CSR map, shared types and the write-merge helper for the M-mode CSR unit; import where needed
package csr_pkg;

	localparam int XLEN  = 32; // Data width
	localparam int N_IRQ = 16; // External interrupt lines

	// ------------------------------------------------------------------------
	// CSR addresses
	localparam logic [11:0] CSR_MSTATUS   = 12'h300;
	localparam logic [11:0] CSR_MIE       = 12'h304;
	localparam logic [11:0] CSR_MTVEC     = 12'h305;
	localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
	localparam logic [11:0] CSR_MEPC      = 12'h341;
	localparam logic [11:0] CSR_MCAUSE    = 12'h342;
	localparam logic [11:0] CSR_MIP       = 12'h344; // Read-only, writes dropped
	localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
	localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
	localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
	localparam logic [11:0] CSR_MINSTRETH = 12'hB82;

	localparam logic [XLEN-1:0] MIE_RSVD_MASK = 32'h0000_F777; // mie bits tied to 0
	localparam int IRQ_CAUSE_BASE = 16; // Vector slot of IRQ 0

	typedef enum logic [1:0] {
		CSR_OP_WRITE = 2'd0,
		CSR_OP_SET   = 2'd1,
		CSR_OP_CLEAR = 2'd2
	} csr_op_e;

	typedef enum logic {
		TRAP_IDLE   = 1'b0,
		TRAP_ACTIVE = 1'b1 // Inside a handler, exceptions blocked
	} trap_state_e;

	// ------------------------------------------------------------------------
	// Bundles
	typedef struct packed {
		logic            ren;
		logic            wen;
		csr_op_e         op;
		logic [11:0]     addr;
		logic [XLEN-1:0] wdata;
	} csr_req_t;

	typedef struct packed {
		logic mstatus, mie, mtvec, mscratch, mepc, mcause;
		logic mcycle, mcycleh, minstret, minstreth;
	} csr_wsel_t; // One-hot write strobes

	typedef struct packed {
		logic [XLEN-1:0] mstatus, mie, mtvec, mscratch, mepc, mcause;
	} trap_csr_t; // Software-visible view

	typedef struct packed {
		logic [63:0] mcycle, minstret;
	} ctr_val_t;

	typedef struct packed {
		logic instr_misaligned, instr_fault, instr_invalid, breakpoint;
		logic load_misaligned, load_fault, store_misaligned, store_fault, ecall;
	} except_req_t;

	typedef struct packed {
		logic       is_irq; // mcause bit 31
		logic [4:0] code;
	} trap_cause_t;

	// Apply a CSR write, set or clear to the old value
	function automatic logic [XLEN-1:0] csr_merge(input logic [XLEN-1:0] old_val,
		input logic [XLEN-1:0] data, input csr_op_e op);
		case (op)
			CSR_OP_SET:   return old_val | data;
			CSR_OP_CLEAR: return old_val & ~data;
			default:      return data; // Plain write
		endcase
	endfunction

endpackage

/* rtl/csr_access_decode.sv */
// CSR address decoder; turns one access into write strobes, read data and an unmapped-access flag
`timescale 1ns/100ps

module csr_access_decode import csr_pkg::*; (
	input  csr_req_t        req,
	input  trap_csr_t       trap_csrs,
	input  ctr_val_t        ctrs,
	input  logic [XLEN-1:0] mip,
	output csr_wsel_t       wsel,
	output logic [XLEN-1:0] rdata,
	output logic            access_err
);

	logic hit; // Address is one of ours

	// ------------------------------------------------------------------------
	// Address match and read mux
	always_comb begin
		hit   = 1'b1;
		rdata = '0;
		case (req.addr)
			CSR_MSTATUS:   rdata = trap_csrs.mstatus; // MIE/MPIE only
			CSR_MIE:       rdata = trap_csrs.mie;
			CSR_MTVEC:     rdata = {trap_csrs.mtvec[XLEN-1:2], 2'b01}; // Always vectored
			CSR_MSCRATCH:  rdata = trap_csrs.mscratch;
			CSR_MEPC:      rdata = trap_csrs.mepc;
			CSR_MCAUSE:    rdata = trap_csrs.mcause;
			CSR_MIP:       rdata = mip; // Mapped but a write has no target
			CSR_MCYCLE:    rdata = ctrs.mcycle[31:0];
			CSR_MCYCLEH:   rdata = ctrs.mcycle[63:32];
			CSR_MINSTRET:  rdata = ctrs.minstret[31:0];
			CSR_MINSTRETH: rdata = ctrs.minstret[63:32];
			default:       hit = 1'b0; // Unmapped
		endcase
	end

	// Write strobes from their own address compares
	assign wsel = '{
		mstatus:   req.wen & (req.addr == CSR_MSTATUS),
		mie:       req.wen & (req.addr == CSR_MIE),
		mtvec:     req.wen & (req.addr == CSR_MTVEC),
		mscratch:  req.wen & (req.addr == CSR_MSCRATCH),
		mepc:      req.wen & (req.addr == CSR_MEPC),
		mcause:    req.wen & (req.addr == CSR_MCAUSE),
		mcycle:    req.wen & (req.addr == CSR_MCYCLE),
		mcycleh:   req.wen & (req.addr == CSR_MCYCLEH),
		minstret:  req.wen & (req.addr == CSR_MINSTRET),
		minstreth: req.wen & (req.addr == CSR_MINSTRETH)
	};

	// Unmapped CSR becomes an illegal instruction further on
	assign access_err = (req.ren | req.wen) & ~hit;

	// Both register blocks rely on never seeing two strobes at once
	always_comb begin
		assert ($onehot0(wsel))
			else $error("csr_access_decode: more than one write strobe");
	end

endmodule

/* rtl/csr_trap_regs.sv */
// Trap-setup and trap-handling CSRs; written by software and updated on trap entry and exit
`timescale 1ns/100ps

module csr_trap_regs import csr_pkg::*; #(
	parameter logic [XLEN-1:0] MTVEC_WMASK = 32'hFFFF_F000, // Writable mtvec bits
	parameter logic [XLEN-1:0] MTVEC_INIT  = 32'h0000_0000  // Reset and fixed mtvec bits
) (
	input  logic            clk,
	input  logic            rst_n,
	input  csr_wsel_t       wsel,
	input  csr_op_e         op,
	input  logic [XLEN-1:0] wdata,
	input  logic            trap_enter_fire,
	input  logic            trap_exit,
	input  trap_cause_t     cause,
	input  logic [XLEN-1:0] mepc_in,
	output trap_csr_t       trap_csrs,
	output logic [XLEN-1:0] mepc_out
);

	localparam logic [XLEN-1:0] MEPC_MASK = {{(XLEN-1){1'b1}}, 1'b0}; // Bit 0 always 0

	logic            mstatus_mie;  // Global interrupt enable
	logic            mstatus_mpie; // Previous MIE, one level of stack
	logic [XLEN-1:0] mscratch_q;
	logic [XLEN-1:0] mtvec_q;
	logic [XLEN-1:0] mepc_q;
	logic [XLEN-1:0] mie_q;
	logic            mcause_irq;
	logic [4:0]      mcause_code;

	logic [XLEN-1:0] mstatus_val, mcause_val; // Assembled read views
	logic [XLEN-1:0] mstatus_wr, mcause_wr;   // After write/set/clear

	assign mstatus_val = {{(XLEN-8){1'b0}}, mstatus_mpie, 3'b000, mstatus_mie, 3'b000};
	assign mcause_val  = {mcause_irq, {(XLEN-6){1'b0}}, mcause_code};
	assign mstatus_wr  = csr_merge(mstatus_val, wdata, op);
	assign mcause_wr   = csr_merge(mcause_val, wdata, op);

	// ------------------------------------------------------------------------
	// Registers touched by trap entry/exit; hardware beats software
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
			mepc_q       <= '0;
			mcause_irq   <= 1'b0;
			mcause_code  <= '0;
		end else if (trap_enter_fire) begin
			mstatus_mpie <= mstatus_mie; // Push enable
			mstatus_mie  <= 1'b0;
			mepc_q       <= mepc_in & MEPC_MASK;
			mcause_irq   <= cause.is_irq;
			mcause_code  <= cause.code;
		end else begin
			if (trap_exit) begin
				mstatus_mie  <= mstatus_mpie; // Pop enable
				mstatus_mpie <= 1'b1;
			end else if (wsel.mstatus) begin
				mstatus_mie  <= mstatus_wr[3];
				mstatus_mpie <= mstatus_wr[7];
			end
			if (wsel.mepc)
				mepc_q <= csr_merge(mepc_q, wdata, op) & MEPC_MASK;
			if (wsel.mcause) begin
				mcause_irq  <= mcause_wr[XLEN-1];
				mcause_code <= mcause_wr[4:0]; // Rest of mcause is tied off
			end
		end
	end

	// ------------------------------------------------------------------------
	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch_q <= '0;
			mtvec_q    <= MTVEC_INIT;
			mie_q      <= '0;
		end else begin
			if (wsel.mscratch)
				mscratch_q <= csr_merge(mscratch_q, wdata, op);
			if (wsel.mtvec) // Fixed bits forced back to their init value
				mtvec_q <= (csr_merge(mtvec_q, wdata, op) & MTVEC_WMASK)
					| (MTVEC_INIT & ~MTVEC_WMASK);
			if (wsel.mie)
				mie_q <= csr_merge(mie_q, wdata, op) & ~MIE_RSVD_MASK;
		end
	end

	assign trap_csrs = '{
		mstatus:  mstatus_val,
		mie:      mie_q,
		mtvec:    mtvec_q,
		mscratch: mscratch_q,
		mepc:     mepc_q,
		mcause:   mcause_val
	};
	assign mepc_out = mepc_q; // Return address for mret

	// The core must never retire into and out of a trap on the same edge
	ap_no_enter_exit: assert property (@(posedge clk) disable iff (!rst_n)
		!(trap_enter_fire && trap_exit))
		else $error("csr_trap_regs: trap entry and exit in the same cycle");

endmodule

/* rtl/csr_counters.sv */
// Cycle and retired-instruction counters; low W_COUNTER bits count, all 64 bits stay writable
`timescale 1ns/100ps

module csr_counters import csr_pkg::*; #(
	parameter int W_COUNTER = 64 // Hardware-counted width
) (
	input  logic            clk,
	input  logic            rst_n,
	input  csr_wsel_t       wsel,
	input  csr_op_e         op,
	input  logic [XLEN-1:0] wdata,
	input  logic            instr_ret,
	output ctr_val_t        ctrs
);

	// Bits the incrementer may change; the rest only move on a write
	localparam logic [63:0] HW_MASK = ~({64{1'b1}} << W_COUNTER);

	logic [63:0] mcycle_q;
	logic [63:0] minstret_q;

	// Next value of one counter; a written word overrides its increment
	function automatic logic [63:0] ctr_next(input logic [63:0] cur, input logic inc,
		input logic wr_lo, input logic wr_hi);
		logic [63:0] nxt;
		nxt = cur;
		if (inc)
			nxt = ((cur + 64'd1) & HW_MASK) | (cur & ~HW_MASK); // Upper bits hold
		if (wr_lo)
			nxt[31:0] = csr_merge(cur[31:0], wdata, op);
		if (wr_hi)
			nxt[63:32] = csr_merge(cur[63:32], wdata, op);
		return nxt;
	endfunction

	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcycle_q   <= '0;
			minstret_q <= '0;
		end else begin
			mcycle_q   <= ctr_next(mcycle_q, 1'b1, wsel.mcycle, wsel.mcycleh); // Every clock
			minstret_q <= ctr_next(minstret_q, instr_ret, wsel.minstret, wsel.minstreth);
		end
	end

	assign ctrs = '{mcycle: mcycle_q, minstret: minstret_q};

endmodule

/* rtl/trap_select.sv */
// Trap source selection; registers IRQs, builds mip, picks the winning cause and vector address
`timescale 1ns/100ps

module trap_select import csr_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [N_IRQ-1:0] irq,
	input  except_req_t      except,
	input  logic             access_err,
	input  trap_csr_t        trap_csrs,
	output logic [XLEN-1:0]  mip,
	output logic             exc_pending,
	output logic             irq_pending,
	output trap_cause_t      cause,
	output logic [XLEN-1:0]  trap_addr
);

	logic [N_IRQ-1:0] irq_q;    // Sampled lines, these are mip[31:16]
	logic [15:0]      exc_vec;  // Indexed by exception code
	logic [N_IRQ-1:0] irq_req;  // Pending and enabled
	logic [3:0]       exc_code;
	logic [3:0]       irq_code;
	logic [5:0]       vec_slot; // Vector table entry

	// Lowest set bit wins
	function automatic logic [3:0] lowest_set(input logic [15:0] v);
		logic [3:0] idx;
		idx = '0;
		for (int i = 15; i >= 0; i--) begin
			if (v[i])
				idx = 4'(i);
		end
		return idx;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq_q <= '0;
		else
			irq_q <= irq;
	end

	// Per-line bits on top, MEIP as their OR
	assign mip = {irq_q, 4'b0000, |irq_q, 11'b0};

	// ------------------------------------------------------------------------
	// Exceptions, standard codes
	assign exc_vec = {
		4'b0000,
		except.ecall,        // 11, M-mode ecall
		3'b000,
		except.store_fault,
		except.store_misaligned,
		except.load_fault,
		except.load_misaligned,
		except.breakpoint,
		except.instr_invalid | access_err, // Bad CSR is illegal instruction
		except.instr_fault,
		except.instr_misaligned
	};
	assign exc_pending = |exc_vec;
	assign exc_code    = lowest_set(exc_vec);

	// Interrupts, gated by per-line enable, meie and MIE
	assign irq_req     = irq_q & trap_csrs.mie[31:16]
		& {N_IRQ{trap_csrs.mie[11] & trap_csrs.mstatus[3]}};
	assign irq_code    = lowest_set(irq_req);
	assign irq_pending = |irq_req & ~exc_pending; // Exceptions always win

	assign cause = exc_pending ? '{is_irq: 1'b0, code: {1'b0, exc_code}}
		: '{is_irq: 1'b1, code: {1'b0, irq_code}};

	assign vec_slot  = exc_pending ? {2'b00, exc_code} : 6'(IRQ_CAUSE_BASE) + {2'b00, irq_code};
	assign trap_addr = {trap_csrs.mtvec[XLEN-1:2], 2'b00} | {{(XLEN-8){1'b0}}, vec_slot, 2'b00};

endmodule

/* rtl/trap_fsm.sv */
// Trap state machine; blocks nested exceptions and runs the valid/ready trap entry handshake
`timescale 1ns/100ps

module trap_fsm import csr_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic exc_pending,
	input  logic irq_pending,
	input  logic trap_enter_rdy,
	input  logic trap_exit,
	output logic trap_enter_vld,
	output logic trap_enter_fire
);

	trap_state_e state_q, state_d;

	// Request drops by itself if its source goes away
	assign trap_enter_vld  = irq_pending | (exc_pending & (state_q == TRAP_IDLE));
	assign trap_enter_fire = trap_enter_vld & trap_enter_rdy; // Transfer

	// ------------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			TRAP_IDLE: begin
				if (trap_enter_fire)
					state_d = TRAP_ACTIVE;
			end
			TRAP_ACTIVE: begin
				if (trap_exit)
					state_d = TRAP_IDLE; // mret
			end
			default: state_d = TRAP_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= TRAP_IDLE;
		else
			state_q <= state_d;
	end

	// mret only makes sense from inside a handler
	ap_exit_in_trap: assert property (@(posedge clk) disable iff (!rst_n)
		trap_exit |-> state_q == TRAP_ACTIVE)
		else $error("trap_fsm: trap_exit outside a trap");

	// Exit is a single-cycle pulse from the core
	ap_exit_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		trap_exit |=> !trap_exit)
		else $error("trap_fsm: trap_exit held for two cycles");

endmodule

/* rtl/csr_unit.sv */
// Top of the machine-mode CSR unit; connects decode, registers, counters and trap logic
`timescale 1ns/100ps

module csr_unit import csr_pkg::*; #(
	parameter logic [XLEN-1:0] MTVEC_WMASK = 32'hFFFF_F000, // Writable mtvec bits
	parameter logic [XLEN-1:0] MTVEC_INIT  = 32'h0000_0000, // mtvec after reset
	parameter int              W_COUNTER   = 64             // Hardware counter width
) (
	input  logic             clk,
	input  logic             rst_n,
	// CSR access port
	input  csr_req_t         req,
	output logic [XLEN-1:0]  rdata,
	// Trap sources and core status
	input  logic [N_IRQ-1:0] irq,
	input  except_req_t      except,
	input  logic             instr_ret,
	input  logic [XLEN-1:0]  mepc_in,
	// Trap handshake
	input  logic             trap_enter_rdy,
	input  logic             trap_exit,
	output logic             trap_enter_vld,
	output logic [XLEN-1:0]  trap_addr,
	output logic [XLEN-1:0]  mepc_out
);

	csr_wsel_t       wsel;
	trap_csr_t       trap_csrs;
	ctr_val_t        ctrs;
	logic [XLEN-1:0] mip;
	logic            access_err;
	logic            exc_pending, irq_pending;
	trap_cause_t     cause;
	logic            trap_enter_fire; // Handshake completed

	// ------------------------------------------------------------------------
	csr_access_decode csr_access_decode_inst (
		.req, .trap_csrs, .ctrs, .mip, .wsel, .rdata, .access_err
	);

	csr_trap_regs #(
		.MTVEC_WMASK (MTVEC_WMASK),
		.MTVEC_INIT  (MTVEC_INIT)
	) csr_trap_regs_inst (
		.clk, .rst_n, .wsel,
		.op              (req.op),
		.wdata           (req.wdata),
		.trap_enter_fire, .trap_exit, .cause, .mepc_in, .trap_csrs, .mepc_out
	);

	csr_counters #(
		.W_COUNTER (W_COUNTER)
	) csr_counters_inst (
		.clk, .rst_n, .wsel,
		.op        (req.op),
		.wdata     (req.wdata),
		.instr_ret, .ctrs
	);

	trap_select trap_select_inst (
		.clk, .rst_n, .irq, .except, .access_err, .trap_csrs,
		.mip, .exc_pending, .irq_pending, .cause, .trap_addr
	);

	trap_fsm trap_fsm_inst (
		.clk, .rst_n, .exc_pending, .irq_pending,
		.trap_enter_rdy, .trap_exit, .trap_enter_vld, .trap_enter_fire
	);

endmodule

/* verif/csr_unit_tb.sv */
// Self-checking testbench for the CSR unit; run as top with the project file list
`timescale 1ns/100ps

module csr_unit_tb import csr_pkg::*; ();

	localparam int CLK_PERIOD   = 4;     // ns
	localparam int SEED         = 18032;
	localparam int RESET_CYCLES = 8;
	// Worst-case cycles per test with random lengths at their maximum
	localparam int TEST_CYCLES  = RESET_CYCLES + 30 + 8 + 20 + 14 + 70;
	localparam int WATCHDOG_NS  = 2 * TEST_CYCLES * CLK_PERIOD;

	// CSRs that read zero after reset (mcycle already counts)
	localparam logic [11:0] ZERO_CSRS [9] = '{CSR_MSTATUS, CSR_MIE, CSR_MSCRATCH, CSR_MEPC,
		CSR_MCAUSE, CSR_MIP, CSR_MCYCLEH, CSR_MINSTRET, CSR_MINSTRETH};

	logic             clk;
	logic             rst_n;
	csr_req_t         req;
	logic [XLEN-1:0]  rdata;
	logic [N_IRQ-1:0] irq;
	except_req_t      except;
	logic             instr_ret;
	logic [XLEN-1:0]  mepc_in;
	logic             trap_enter_rdy;
	logic             trap_exit;
	logic             trap_enter_vld;
	logic [XLEN-1:0]  trap_addr;
	logic [XLEN-1:0]  mepc_out;

	int              checks;     // Immediate checks run
	int              errors;     // Immediate check failures
	int              hold_errs;  // Back-pressure property failures
	int              mepc_errs;  // mepc alignment failures
	int              err_mark;   // Total at start of current test
	int              tests_done;
	logic            hold_chk;   // Stall window under check
	logic [XLEN-1:0] mtvec_base; // Vector table base as software set it

	csr_unit csr_unit_inst (
		.clk, .rst_n, .req, .rdata, .irq, .except, .instr_ret, .mepc_in,
		.trap_enter_rdy, .trap_exit, .trap_enter_vld, .trap_addr, .mepc_out
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// Reference model and check helpers
	function automatic logic [XLEN-1:0] expect_merge(input logic [XLEN-1:0] old_val,
		input logic [XLEN-1:0] data, input csr_op_e op);
		logic [XLEN-1:0] res;
		res = data; // Plain write
		if (op == CSR_OP_SET)
			res = old_val | data;
		else if (op == CSR_OP_CLEAR)
			res = old_val & ~data;
		return res;
	endfunction

	function automatic int total_errors();
		return errors + hold_errs + mepc_errs;
	endfunction

	function automatic csr_req_t read_req(input logic [11:0] addr);
		return '{ren: 1'b1, wen: 1'b0, op: CSR_OP_WRITE, addr: addr, wdata: '0};
	endfunction

	task automatic check_eq(input string what, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		check_eq(what, {31'b0, got}, {31'b0, exp});
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("Test %s done, %0d errors", name, total_errors() - err_mark);
		err_mark = total_errors();
	endtask

	// ------------------------------------------------------------------------
	// Bus and handshake drivers
	task automatic csr_write(input logic [11:0] addr, input csr_op_e op,
		input logic [XLEN-1:0] data);
		@(posedge clk);
		req <= '{ren: 1'b0, wen: 1'b1, op: op, addr: addr, wdata: data};
	endtask

	task automatic csr_read(input logic [11:0] addr, output logic [XLEN-1:0] data);
		@(posedge clk);
		req <= read_req(addr);
		@(negedge clk); // Combinational read settled
		data = rdata;
	endtask

	task automatic req_idle();
		@(posedge clk);
		req <= '0;
	endtask

	task automatic leave_trap(); // mret as a one-cycle pulse
		@(posedge clk);
		except    <= '0;
		req       <= '0;
		trap_exit <= 1'b1;
		@(posedge clk);
		trap_exit <= 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// Tests
	task automatic test_register_access();
		logic [XLEN-1:0] rd, d, scratch;
		csr_op_e         op;
		foreach (ZERO_CSRS[i]) begin
			csr_read(ZERO_CSRS[i], rd);
			check_eq($sformatf("CSR 0x%03h after reset", ZERO_CSRS[i]), rd, '0);
		end
		csr_read(CSR_MTVEC, rd);
		check_eq("mtvec after reset", rd, 32'h0000_0001); // Vectored mode
		scratch = '0;
		for (int i = 0; i < 3; i++) begin // Write, set, clear
			op = csr_op_e'(i);
			d  = $urandom;
			csr_write(CSR_MSCRATCH, op, d);
			scratch = expect_merge(scratch, d, op);
			csr_read(CSR_MSCRATCH, rd);
			check_eq("mscratch", rd, scratch);
		end
		d = $urandom;
		csr_write(CSR_MIE, CSR_OP_WRITE, d);
		csr_read(CSR_MIE, rd);
		check_eq("mie", rd, d & 32'hFFFF_0888); // Reserved bits read 0
		d = $urandom;
		csr_write(CSR_MTVEC, CSR_OP_WRITE, d);
		csr_read(CSR_MTVEC, rd);
		check_eq("mtvec", rd, (d & 32'hFFFF_F000) | 32'h1);
		mtvec_base = d & 32'hFFFF_F000;
		req_idle();
	endtask

	task automatic test_unmapped();
		@(posedge clk);
		req            <= read_req(12'hF11); // Nothing lives here
		mepc_in        <= $urandom;
		trap_enter_rdy <= 1'b1;
		@(negedge clk);
		check_bit("trap_enter_vld on unmapped read", trap_enter_vld, 1'b1);
		check_eq("trap_addr for illegal instruction", trap_addr, mtvec_base + 32'd8);
		@(posedge clk); // Transfer
		trap_enter_rdy <= 1'b0;
		req            <= read_req(CSR_MCAUSE);
		@(negedge clk);
		check_eq("mcause after illegal access", rdata, 32'd2);
		leave_trap();
	endtask

	task automatic test_exception_backpressure();
		int              hold;
		logic [XLEN-1:0] rd, epc, cause_before;
		epc  = $urandom | 32'h1; // Odd so that the bit-0 clear shows
		hold = 1 + ($urandom % 8);
		csr_read(CSR_MCAUSE, cause_before);
		@(posedge clk);
		except  <= '{load_fault: 1'b1, ecall: 1'b1, default: 1'b0};
		mepc_in <= epc;
		@(negedge clk);
		check_bit("trap_enter_vld on exception", trap_enter_vld, 1'b1);
		check_eq("trap_addr for load fault", trap_addr, mtvec_base + 32'd20);
		repeat (hold) begin // Core stalls and the request must hold
			@(posedge clk);
			hold_chk <= 1'b1;
			@(negedge clk);
			check_bit("trap_enter_vld while stalled", trap_enter_vld, 1'b1);
			check_eq("mcause while stalled", rdata, cause_before);
		end
		@(posedge clk);
		hold_chk       <= 1'b0;
		trap_enter_rdy <= 1'b1;
		@(posedge clk); // Transfer
		trap_enter_rdy <= 1'b0;
		except         <= '0;
		req            <= read_req(CSR_MEPC);
		@(negedge clk);
		check_eq("mepc after entry", rdata, epc & ~32'h1);
		check_eq("mepc_out after entry", mepc_out, epc & ~32'h1);
		csr_read(CSR_MCAUSE, rd);
		check_eq("mcause after load fault", rd, 32'd5);
		@(posedge clk);
		except <= '{breakpoint: 1'b1, default: 1'b0}; // Nested exception stays masked
		@(negedge clk);
		check_bit("trap_enter_vld for nested exception", trap_enter_vld, 1'b0);
		leave_trap();
	endtask

	task automatic test_interrupts();
		logic [XLEN-1:0] rd;
		csr_write(CSR_MIE, CSR_OP_WRITE, 32'h0020_0800);    // Line 5 and meie
		csr_write(CSR_MSTATUS, CSR_OP_SET, 32'h0000_0008);  // MIE
		@(posedge clk);
		req <= '0;
		irq <= 16'h0220; // Lines 5 and 9 with only 5 enabled
		@(negedge clk);
		check_bit("trap_enter_vld before lines sampled", trap_enter_vld, 1'b0);
		@(posedge clk);
		trap_enter_rdy <= 1'b1;
		@(negedge clk);
		check_bit("trap_enter_vld on interrupt", trap_enter_vld, 1'b1);
		check_eq("trap_addr for line 5", trap_addr, mtvec_base + 32'd84);
		@(posedge clk); // Transfer
		trap_enter_rdy <= 1'b0;
		irq            <= '0;
		req            <= read_req(CSR_MCAUSE);
		@(negedge clk);
		check_eq("mcause for line 5", rdata, 32'h8000_0005);
		csr_read(CSR_MSTATUS, rd);
		check_bit("mstatus.MIE in handler", rd[3], 1'b0);
		check_bit("mstatus.MPIE in handler", rd[7], 1'b1);
		leave_trap();
		csr_read(CSR_MSTATUS, rd);
		check_bit("mstatus.MIE after exit", rd[3], 1'b1);
		csr_write(CSR_MSTATUS, CSR_OP_CLEAR, 32'h0000_0008);
		req_idle();
	endtask

	task automatic test_counters();
		int              gap, len, pulses;
		logic [XLEN-1:0] c0, c1, d;
		gap = 4 + ($urandom % 20);
		len = 8 + ($urandom % 24);
		csr_read(CSR_MCYCLE, c0);
		repeat (gap - 1) @(posedge clk);
		csr_read(CSR_MCYCLE, c1);
		check_eq("mcycle difference", c1 - c0, gap);
		pulses = 0;
		csr_read(CSR_MINSTRET, c0);
		repeat (len) begin
			@(posedge clk);
			d         = $urandom;
			instr_ret <= d[0];
			pulses    += int'(d[0]);
		end
		@(posedge clk);
		instr_ret <= 1'b0;
		req       <= read_req(CSR_MINSTRET);
		@(negedge clk);
		check_eq("minstret difference", rdata - c0, pulses);
		d = $urandom;
		csr_write(CSR_MCYCLEH, CSR_OP_WRITE, d);
		csr_read(CSR_MCYCLEH, c1);
		check_eq("mcycleh after write", c1, d);
		req_idle();
	endtask

	// ------------------------------------------------------------------------
	// Properties watched over the whole run
	ap_hold: assert property (@(posedge clk) disable iff (!rst_n)
		hold_chk |=> trap_enter_vld && $stable(trap_addr))
		else begin
			$display("ERROR %0t: trap request or vector changed under back-pressure", $time);
			hold_errs++;
		end

	ap_mepc_even: assert property (@(posedge clk) disable iff (!rst_n) !mepc_out[0])
		else begin
			$display("ERROR %0t: mepc_out has bit 0 set", $time);
			mepc_errs++;
		end

	initial begin
		void'($urandom(SEED));
		clk            = 1'b0;
		rst_n          = 1'b0;
		req            = '0;
		irq            = '0;
		except         = '0;
		instr_ret      = 1'b0;
		mepc_in        = '0;
		trap_enter_rdy = 1'b0;
		trap_exit      = 1'b0;
		hold_chk       = 1'b0;
		mtvec_base     = '0;
		checks         = 0;
		errors         = 0;
		hold_errs      = 0;
		mepc_errs      = 0;
		err_mark       = 0;
		tests_done     = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		test_register_access();
		finish_test("register access");
		test_unmapped();
		finish_test("unmapped access");
		test_exception_backpressure();
		finish_test("exception priority and back-pressure");
		test_interrupts();
		finish_test("interrupts");
		test_counters();
		finish_test("counters");
		$display("Tests: %0d, checks: %0d, errors: %0d", tests_done, checks, total_errors());
		if (total_errors() == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog at twice the worst-case run length
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not complete within %0d ns", WATCHDOG_NS);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* project.f */
rtl/csr_pkg.sv
rtl/csr_access_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_counters.sv
rtl/trap_select.sv
rtl/trap_fsm.sv
rtl/csr_unit.sv
verif/csr_unit_tb.sv

/* Makefile */
# Verilator flow for the CSR unit: lint, simulate, clean
TOP := csr_unit_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "sim: failure found in sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
